//--- hw/spi_config.svh
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// ncs debounce
////////////////////////////////////////////////////////////////////////////

// up/down counter width, saturates at all ones
`define SPI_NCS_CNT_W 4

// frame opens below this count
`define SPI_NCS_LOW_TH 4

// frame closes at or above this count
`define SPI_NCS_HIGH_TH 12

////////////////////////////////////////////////////////////////////////////
// sck / mosi sampling and register file
////////////////////////////////////////////////////////////////////////////

// sample shift depth, majority vote needs at least three
`define SPI_SYNC_STAGES 3

`define SPI_REG_COUNT 8

`endif

//--- hw/spi_pkg.sv
package spi_pkg;

    ////////////////////////////////////////////////////////////////////////
    // frame words
    ////////////////////////////////////////////////////////////////////////

    // register index, wraps modulo eight
    typedef logic [2:0] spi_addr_t;

    // first byte of a frame
    typedef struct packed
    {
        logic      wr;    // 1 write, 0 read
        logic [3:0] rsvd; // don't care
        spi_addr_t addr;  // start address
    } spi_cmd_t;

    // received byte, meaning depends on position in frame
    typedef union packed
    {
        spi_cmd_t   cmd;  // byte 0 of the frame
        logic [7:0] data; // every later byte
    } spi_byte_t;

endpackage

//--- hw/spi_line_filter.sv
`timescale 1ns/1ps
`include "spi_config.svh"

module spi_line_filter
(
    input  logic clk,
    input  logic nrst,
    input  logic ncs,
    input  logic sck,
    input  logic mosi,
    output logic frame_active,
    output logic sck_rise,
    output logic sck_fall,
    output logic mosi_filt
);

    localparam int SYNC_W = `SPI_SYNC_STAGES;

    typedef logic [`SPI_NCS_CNT_W-1:0] cnt_t;

    localparam cnt_t CNT_MAX  = {`SPI_NCS_CNT_W{1'b1}};
    localparam cnt_t CNT_LOW  = cnt_t'(`SPI_NCS_LOW_TH);
    localparam cnt_t CNT_HIGH = cnt_t'(`SPI_NCS_HIGH_TH);

    logic [1:0]        ncs_sync;
    cnt_t              ncs_cnt;
    logic [SYNC_W-1:0] sck_sr;
    logic              sck_level;
    logic [SYNC_W-1:0] mosi_sr;

    ////////////////////////////////////////////////////////////////////////
    // ncs: two-flop sync, then saturating up/down counter
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            ncs_sync     <= 2'b11;
            ncs_cnt      <= CNT_MAX;
            frame_active <= 1'b0;
        end
        else
        begin
            ncs_sync <= {ncs_sync[0], ncs};
            // count up while deasserted, down while asserted
            if (ncs_sync[1])
            begin
                if (ncs_cnt != CNT_MAX)
                begin
                    ncs_cnt <= ncs_cnt + cnt_t'(1);
                end
            end
            else if (ncs_cnt != '0)
            begin
                ncs_cnt <= ncs_cnt - cnt_t'(1);
            end
            // hysteresis band, hold state between thresholds
            if (ncs_cnt < CNT_LOW)
            begin
                frame_active <= 1'b1;
            end
            else if (ncs_cnt >= CNT_HIGH)
            begin
                frame_active <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // sck and mosi sample shift registers
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            sck_sr    <= '0;
            sck_level <= 1'b0;
            mosi_sr   <= '0;
        end
        else
        begin
            sck_sr  <= {sck_sr[SYNC_W-2:0], sck};
            mosi_sr <= {mosi_sr[SYNC_W-2:0], mosi};
            // debounced sck level, flips only on a stable run
            if (sck_rise)
            begin
                sck_level <= 1'b1;
            end
            else if (sck_fall)
            begin
                sck_level <= 1'b0;
            end
        end
    end

    // edge = all samples agree and differ from the held level
    assign sck_rise = (&sck_sr) & ~sck_level;
    assign sck_fall = ~(|sck_sr) & sck_level;

    // 2 of 3 vote on the oldest samples
    assign mosi_filt = (mosi_sr[SYNC_W-1] & mosi_sr[SYNC_W-2]) |
                       (mosi_sr[SYNC_W-1] & mosi_sr[SYNC_W-3]) |
                       (mosi_sr[SYNC_W-2] & mosi_sr[SYNC_W-3]);

endmodule

//--- hw/spi_rx_shifter.sv
`timescale 1ns/1ps

module spi_rx_shifter
(
    input  logic               clk,
    input  logic               nrst,
    input  logic               frame_active,
    input  logic               sck_rise,
    input  logic               mosi_filt,
    output logic               rx_valid,
    output spi_pkg::spi_byte_t rx_byte
);

    logic [7:0] shift_q;
    logic [2:0] bit_cnt;

    ////////////////////////////////////////////////////////////////////////
    // bit counter and byte strobe
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            bit_cnt  <= 3'd0;
            rx_valid <= 1'b0;
        end
        else
        begin
            // strobe is a single cycle
            rx_valid <= 1'b0;
            if (!frame_active)
            begin
                // drop any partial byte
                bit_cnt <= 3'd0;
            end
            else if (sck_rise)
            begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7)
                begin
                    rx_valid <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // data path, MSB first
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (frame_active && sck_rise)
        begin
            shift_q <= {shift_q[6:0], mosi_filt};
            // eighth bit completes the byte
            if (bit_cnt == 3'd7)
            begin
                rx_byte.data <= {shift_q[6:0], mosi_filt};
            end
        end
    end

endmodule

//--- hw/spi_tx_shifter.sv
`timescale 1ns/1ps

module spi_tx_shifter
(
    input  logic       clk,
    input  logic       nrst,
    input  logic       frame_active,
    input  logic       sck_fall,
    input  logic [7:0] tx_byte,
    output logic       miso
);

    logic       loaded;
    logic [2:0] bit_cnt;
    logic [6:0] shift_q;
    logic       miso_q;

    ////////////////////////////////////////////////////////////////////////
    // load / shift control
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            loaded  <= 1'b0;
            bit_cnt <= 3'd0;
            miso_q  <= 1'b0;
        end
        else if (!frame_active)
        begin
            // idle, line parked low
            loaded  <= 1'b0;
            bit_cnt <= 3'd0;
            miso_q  <= 1'b0;
        end
        else if (!loaded)
        begin
            // frame start, MSB out before the first rise
            loaded  <= 1'b1;
            bit_cnt <= 3'd0;
            miso_q  <= tx_byte[7];
        end
        else if (sck_fall)
        begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
            begin
                // byte boundary, next byte's MSB
                miso_q <= tx_byte[7];
            end
            else
            begin
                miso_q <= shift_q[6];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // remaining bits of the current byte
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (frame_active && !loaded)
        begin
            shift_q <= tx_byte[6:0];
        end
        else if (frame_active && sck_fall)
        begin
            if (bit_cnt == 3'd7)
            begin
                shift_q <= tx_byte[6:0];
            end
            else
            begin
                shift_q <= {shift_q[5:0], 1'b0};
            end
        end
    end

    // no stale bit once the frame closes
    assign miso = miso_q & frame_active;

endmodule

//--- hw/spi_reg_ctrl.sv
`timescale 1ns/1ps
`include "spi_config.svh"

module spi_reg_ctrl
(
    input  logic               clk,
    input  logic               nrst,
    input  logic               frame_active,
    input  logic               rx_valid,
    input  spi_pkg::spi_byte_t rx_byte,
    output logic [7:0]         tx_byte,
    output logic [63:0]        regs
);

    localparam int NREGS = `SPI_REG_COUNT;

    logic              expect_cmd;
    logic              wr_q;
    spi_pkg::spi_addr_t addr_q;
    logic [7:0]        reg_file [NREGS];
    logic [7:0]        frame_cnt;
    logic              got_byte;
    logic              frame_q;
    logic              frame_end;

    // one cycle after frame_active drops
    assign frame_end = frame_q & ~frame_active;

    ////////////////////////////////////////////////////////////////////////
    // command / data sequencing
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            expect_cmd <= 1'b1;
            wr_q       <= 1'b0;
            addr_q     <= '0;
            got_byte   <= 1'b0;
            frame_q    <= 1'b0;
            frame_cnt  <= 8'd0;
            for (int i = 0; i < NREGS; i++)
            begin
                reg_file[i] <= 8'd0;
            end
        end
        else
        begin
            frame_q <= frame_active;
            if (!frame_active)
            begin
                // next frame starts with a command byte
                expect_cmd <= 1'b1;
                got_byte   <= 1'b0;
            end
            else if (rx_valid)
            begin
                got_byte <= 1'b1;
                if (expect_cmd)
                begin
                    // cmd view of the byte
                    expect_cmd <= 1'b0;
                    wr_q       <= rx_byte.cmd.wr;
                    addr_q     <= rx_byte.cmd.addr;
                end
                else
                begin
                    // data view, reads only advance
                    if (wr_q)
                    begin
                        reg_file[addr_q] <= rx_byte.data;
                    end
                    addr_q <= addr_q + 3'd1;
                end
            end
            // count frames holding a whole byte, wraps at 256
            if (frame_end && got_byte)
            begin
                frame_cnt <= frame_cnt + 8'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////////

    // frame count until the command lands, then the addressed register
    assign tx_byte = expect_cmd ? frame_cnt : reg_file[addr_q];

    // register 0 in the low byte
    for (genvar g = 0; g < NREGS; g++)
    begin : g_flat
        assign regs[8*g +: 8] = reg_file[g];
    end

endmodule

//--- hw/spi_slave_top.sv
`timescale 1ns/1ps

module spi_slave_top
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        ncs,
    input  logic        sck,
    input  logic        mosi,
    output logic        miso,
    output logic [63:0] regs
);

    // conditioned pin state
    logic frame_active;
    logic sck_rise;
    logic sck_fall;
    logic mosi_filt;

    // byte-level traffic
    logic               rx_valid;
    spi_pkg::spi_byte_t rx_byte;
    logic [7:0]         tx_byte;

    ////////////////////////////////////////////////////////////////////////
    // pin conditioning
    ////////////////////////////////////////////////////////////////////////

    spi_line_filter u_filter
    (
        .clk          (clk),
        .nrst         (nrst),
        .ncs          (ncs),
        .sck          (sck),
        .mosi         (mosi),
        .frame_active (frame_active),
        .sck_rise     (sck_rise),
        .sck_fall     (sck_fall),
        .mosi_filt    (mosi_filt)
    );

    ////////////////////////////////////////////////////////////////////////
    // shifters, running side by side
    ////////////////////////////////////////////////////////////////////////

    spi_rx_shifter u_rx
    (
        .clk          (clk),
        .nrst         (nrst),
        .frame_active (frame_active),
        .sck_rise     (sck_rise),
        .mosi_filt    (mosi_filt),
        .rx_valid     (rx_valid),
        .rx_byte      (rx_byte)
    );

    spi_tx_shifter u_tx
    (
        .clk          (clk),
        .nrst         (nrst),
        .frame_active (frame_active),
        .sck_fall     (sck_fall),
        .tx_byte      (tx_byte),
        .miso         (miso)
    );

    // register file and frame counter
    spi_reg_ctrl u_ctrl
    (
        .clk          (clk),
        .nrst         (nrst),
        .frame_active (frame_active),
        .rx_valid     (rx_valid),
        .rx_byte      (rx_byte),
        .tx_byte      (tx_byte),
        .regs         (regs)
    );

endmodule

//--- tb/spi_slave_asserts.sv
`timescale 1ns/1ps

module spi_slave_asserts
(
    input logic clk,
    input logic nrst,
    input logic frame_active,
    input logic rx_valid,
    input logic sck_rise,
    input logic sck_fall,
    input logic miso
);

    // number of assertion failures so far
    int fail_cnt = 0;

    ////////////////////////////////////////////////////////////////////////
    // byte strobe and pin checks
    ////////////////////////////////////////////////////////////////////////

    // byte strobe only while a frame is open
    rx_valid_in_frame: assert property (@(posedge clk) disable iff (!nrst)
        rx_valid |-> frame_active)
    else
    begin
        fail_cnt++;
        $error("rx_valid high while no frame is active");
    end

    // miso moves on the frame start load or after an sck fall and drops at frame end
    miso_changes: assert property (@(posedge clk) disable iff (!nrst)
        $changed(miso) |-> $past(sck_fall) || ($fell(frame_active) && !miso) ||
            ($past(frame_active) && !$past(frame_active, 2)))
    else
    begin
        fail_cnt++;
        $error("miso changed away from a frame start, an sck fall or a frame end");
    end

    // debounced sck edges only inside a frame
    sck_edges_in_frame: assert property (@(posedge clk) disable iff (!nrst)
        (sck_rise || sck_fall) |-> frame_active)
    else
    begin
        fail_cnt++;
        $error("sck edge seen while no frame is active");
    end

endmodule

bind spi_slave_top spi_slave_asserts u_asserts
(
    .clk          (clk),
    .nrst         (nrst),
    .frame_active (frame_active),
    .rx_valid     (rx_valid),
    .sck_rise     (sck_rise),
    .sck_fall     (sck_fall),
    .miso         (miso)
);

//--- tb/tb_spi_slave.sv
`timescale 1ns/1ps
`include "spi_config.svh"

module tb_spi_slave;

    // master timing in clk cycles
    localparam int HALF_CYC  = 10;
    localparam int SETUP_CYC = 20;
    localparam int HOLD_CYC  = 20;
    localparam int GAP_CYC   = 40;
    localparam int REGS_WAIT = 30;
    localparam int BIT_CYC   = 2 * HALF_CYC + 1;

    // run length with partial frames rounded up to a byte
    localparam int N_FRAMES    = 8;
    localparam int N_BYTES     = 33;
    localparam int FRAME_CYC   = N_FRAMES * (SETUP_CYC + HOLD_CYC + GAP_CYC) +
                                 N_BYTES * 8 * BIT_CYC;
    localparam int TIMEOUT_CYC = 2 * FRAME_CYC;

    logic        clk = 1'b0;
    logic        nrst;
    logic        ncs;
    logic        sck;
    logic        mosi;
    logic        miso;
    logic [63:0] regs;

    // master buffers with the command in byte 0
    logic [7:0]  tx_buf [16];
    logic [7:0]  rx_buf [16];

    // reference model state
    logic [7:0]  model_regs [`SPI_REG_COUNT];
    logic [7:0]  model_frames;

    logic [15:0] lfsr_state = 16'd55;
    int          cycle_cnt = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;

    spi_slave_top uut
    (
        .clk  (clk),
        .nrst (nrst),
        .ncs  (ncs),
        .sck  (sck),
        .mosi (mosi),
        .miso (miso),
        .regs (regs)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // random data from a 16-bit Galois LFSR
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // miso byte k of the frame in tx_buf before the model is updated
    function automatic logic [7:0] expect_miso(input int k);
        spi_pkg::spi_cmd_t cmd;
        spi_pkg::spi_addr_t a;
        cmd = tx_buf[0];
        if (k == 0)
            return model_frames;
        a = cmd.addr + spi_pkg::spi_addr_t'(k - 1);
        return model_regs[a];
    endfunction

    // writes with wrap and a frame count only for a whole byte
    function automatic void apply_frame(input int nbits);
        spi_pkg::spi_cmd_t cmd;
        spi_pkg::spi_addr_t a;
        int k;
        if (nbits < 8)
            return;
        cmd = tx_buf[0];
        a = cmd.addr;
        for (k = 1; k < nbits / 8; k++)
        begin
            if (cmd.wr)
                model_regs[a] = tx_buf[k];
            a = a + 3'd1;
        end
        model_frames = model_frames + 8'd1;
    endfunction

    // register 0 in the low byte
    function automatic logic [63:0] model_bus();
        logic [63:0] v;
        int r;
        for (r = 0; r < `SPI_REG_COUNT; r++)
            v[8*r +: 8] = model_regs[r];
        return v;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_regs(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_test(input int num, input string name);
        if (test_errors == 0)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, test_errors);
        test_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // SPI master in mode 0
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic fill_random(input int first, input int count);
        int i;
        for (i = first; i < first + count; i++)
            tx_buf[i] = rand_bits(8);
    endtask

    // nbits may stop mid byte and glitch adds ncs and mosi spikes
    task automatic run_frame(input int nbits, input logic glitch);
        int b;
        int k;
        logic dbit;
        ncs <= 1'b0;
        wait_cycles(SETUP_CYC);
        for (b = 0; b < nbits; b++)
        begin
            if (glitch && b == 8)
            begin
                // short deselect pulse after the command
                ncs <= 1'b1;
                wait_cycles(4);
                ncs <= 1'b0;
                wait_cycles(HALF_CYC);
            end
            dbit = tx_buf[b / 8][7 - b % 8];
            mosi <= dbit;
            if (glitch && b >= 8)
            begin
                // one-cycle spike in the low half
                wait_cycles(4);
                mosi <= ~dbit;
                wait_cycles(1);
                mosi <= dbit;
                wait_cycles(HALF_CYC - 5);
            end
            else
            begin
                wait_cycles(HALF_CYC);
            end
            // miso settled long before the rising edge
            @(negedge clk);
            rx_buf[b / 8][7 - b % 8] = miso;
            @(posedge clk);
            sck <= 1'b1;
            wait_cycles(HALF_CYC);
            sck <= 1'b0;
        end
        wait_cycles(HOLD_CYC);
        ncs <= 1'b1;
        // whole bytes only
        for (k = 0; k < nbits / 8; k++)
            check_byte($sformatf("miso byte %0d", k), rx_buf[k], expect_miso(k));
        apply_frame(nbits);
        wait_cycles(GAP_CYC);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // regs compare after each deselect
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge ncs)
    begin
        if (nrst)
        begin
            wait_cycles(REGS_WAIT);
            check_regs("regs", regs, model_bus());
        end
    end

    // watchdog
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC)
        begin
            $display("run timed out after %0d cycles without finishing", cycle_cnt);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        spi_pkg::spi_cmd_t cmd;
        int i;
        nrst = 1'b0;
        ncs  = 1'b1;
        sck  = 1'b0;
        mosi = 1'b0;
        model_frames = 8'd0;
        for (i = 0; i < `SPI_REG_COUNT; i++)
            model_regs[i] = 8'd0;
        wait_cycles(2);
        nrst <= 1'b1;
        wait_cycles(5);

        // write burst from 5 wrapping through 7 to 0
        cmd.wr   = 1'b1;
        cmd.rsvd = 4'(rand_bits(4));
        cmd.addr = 3'd5;
        tx_buf[0] = cmd;
        fill_random(1, 8);
        run_frame(72, 1'b0);
        report_test(1, "write burst with wrap");

        // read burst from a random start
        cmd.wr   = 1'b0;
        cmd.rsvd = 4'(rand_bits(4));
        cmd.addr = spi_pkg::spi_addr_t'(rand_bits(3));
        tx_buf[0] = cmd;
        fill_random(1, 8);
        run_frame(72, 1'b0);
        report_test(2, "read burst with wrap");

        // command-only frames with the second one too short to count
        for (i = 0; i < 4; i++)
        begin
            cmd.wr   = 1'b0;
            cmd.rsvd = 4'(rand_bits(4));
            cmd.addr = spi_pkg::spi_addr_t'(rand_bits(3));
            tx_buf[0] = cmd;
            run_frame((i == 1) ? 5 : 8, 1'b0);
        end
        report_test(3, "frame counter on miso");

        // write cut after 5 data bits
        cmd.wr   = 1'b1;
        cmd.rsvd = 4'(rand_bits(4));
        cmd.addr = spi_pkg::spi_addr_t'(rand_bits(3));
        tx_buf[0] = cmd;
        fill_random(1, 1);
        run_frame(13, 1'b0);
        report_test(4, "partial data byte");

        // write burst under ncs and mosi glitches
        cmd.wr   = 1'b1;
        cmd.rsvd = 4'(rand_bits(4));
        cmd.addr = 3'd2;
        tx_buf[0] = cmd;
        fill_random(1, 8);
        run_frame(72, 1'b1);
        report_test(5, "glitch rejection");

        errors = errors + uut.u_asserts.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, uut.u_asserts.fail_cnt);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hw
hw/spi_pkg.sv
hw/spi_line_filter.sv
hw/spi_rx_shifter.sv
hw/spi_tx_shifter.sv
hw/spi_reg_ctrl.sv
hw/spi_slave_top.sv
tb/spi_slave_asserts.sv
tb/tb_spi_slave.sv
